//--- verilog/cache_pkg.sv
// Shared definitions for the blocking data cache
// Geometry, request type codes, control encodings and the address view

`default_nettype none

package cache_pkg;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------
  localparam int addr_bits   = 32;
  localparam int word_bits   = 32;
  localparam int line_bits   = 128;
  localparam int line_bytes  = line_bits / 8;
  localparam int num_lines   = 16;
  localparam int index_bits  = 4;
  // Byte offset within a line
  localparam int offset_bits = 4;
  localparam int tag_bits    = addr_bits - index_bits - offset_bits;

  // Request and response type codes
  typedef enum logic [2:0] {
    req_read  = 3'd0,
    req_write = 3'd1,
    req_init  = 3'd2
  } req_type_t;

  // --------------------------------------------------
  // Datapath control encodings
  // --------------------------------------------------
  localparam logic wdata_word   = 1'b0;
  localparam logic wdata_refill = 1'b1;

  localparam logic maddr_evict  = 1'b0;
  localparam logic maddr_refill = 1'b1;

  // Word write enables lane 0, the datapath moves it to the addressed word
  localparam logic [line_bytes-1:0] wben_none = '0;
  localparam logic [line_bytes-1:0] wben_word = 16'h000f;
  localparam logic [line_bytes-1:0] wben_line = 16'hffff;

  // Address as seen by the cache
  typedef struct packed {
    logic [tag_bits-1:0]   tag;
    logic [index_bits-1:0] index;
    logic [1:0]            word_sel;
    logic [1:0]            byte_sel;
  } cache_addr_s;

  typedef union packed {
    logic [addr_bits-1:0] word;
    cache_addr_s          fields;
  } cache_addr_u;

endpackage

`default_nettype wire

//--- verilog/cache_ctrl.sv
// Blocking cache controller
// State machine, valid and dirty bits, datapath enables and handshakes

`default_nettype none

module cache_ctrl (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire logic                                 cachereq_val,
  input  wire logic                                 cacheresp_rdy,
  input  wire logic                                 memreq_rdy,
  input  wire logic                                 memresp_val,
  input  wire logic                                 tag_match,
  input  wire cache_pkg::req_type_t                 req_type,
  input  wire logic [cache_pkg::index_bits-1:0]     req_index,
  output logic                                      cachereq_rdy,
  output logic                                      cacheresp_val,
  output logic                                      memreq_val,
  output logic                                      memresp_rdy,
  output cache_pkg::req_type_t                      memreq_type,
  output cache_pkg::req_type_t                      cacheresp_type,
  output logic                                      req_reg_en,
  output logic                                      tag_array_ren,
  output logic                                      tag_array_wen,
  output logic                                      data_array_ren,
  output logic                                      data_array_wen,
  output logic [cache_pkg::line_bytes-1:0]          data_array_wben,
  output logic                                      write_data_sel,
  output logic                                      evict_addr_reg_en,
  output logic                                      memreq_addr_sel,
  output logic                                      refill_reg_en,
  output logic                                      read_data_reg_en
);

  import cache_pkg::*;

  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_read_access,
    st_write_access,
    st_resp,
    st_evict_prepare,
    st_evict_request,
    st_evict_wait,
    st_refill_request,
    st_refill_wait,
    st_refill_update
  } state_t;

  state_t state;
  state_t state_next;

  logic [num_lines-1:0] valid_bits;
  logic [num_lines-1:0] dirty_bits;
  logic                 hit;
  logic                 victim_dirty;

  assign hit          = valid_bits[req_index] && tag_match;
  assign victim_dirty = valid_bits[req_index] && dirty_bits[req_index];

  // --------------------------------------------------
  // State register and next state
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (cachereq_val) begin
          state_next = st_tag_check;
        end
      end
      st_tag_check: begin
        // Init skips the tag check entirely
        if (req_type == req_init) begin
          state_next = st_write_access;
        end else if (hit) begin
          state_next = (req_type == req_read) ? st_read_access : st_write_access;
        end else if (victim_dirty) begin
          state_next = st_evict_prepare;
        end else begin
          state_next = st_refill_request;
        end
      end
      st_read_access:   state_next = st_resp;
      st_write_access:  state_next = st_resp;
      st_resp: begin
        if (cacheresp_rdy) begin
          state_next = st_idle;
        end
      end
      st_evict_prepare: state_next = st_evict_request;
      st_evict_request: begin
        if (memreq_rdy) begin
          state_next = st_evict_wait;
        end
      end
      st_evict_wait: begin
        // Write acknowledgment from memory
        if (memresp_val) begin
          state_next = st_refill_request;
        end
      end
      st_refill_request: begin
        if (memreq_rdy) begin
          state_next = st_refill_wait;
        end
      end
      st_refill_wait: begin
        if (memresp_val) begin
          state_next = st_refill_update;
        end
      end
      st_refill_update: begin
        // Back to the access the request asked for
        state_next = (req_type == req_read) ? st_read_access : st_write_access;
      end
      default:          state_next = st_idle;
    endcase
  end

  // --------------------------------------------------
  // Valid and dirty bits
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (state == st_refill_update) begin
      valid_bits[req_index] <= 1'b1;
      dirty_bits[req_index] <= 1'b0;
    end else if (state == st_write_access) begin
      if (req_type == req_init) begin
        valid_bits[req_index] <= 1'b1;
        dirty_bits[req_index] <= 1'b0;
      end else begin
        dirty_bits[req_index] <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Control outputs
  // --------------------------------------------------
  assign cacheresp_type = req_type;

  always_comb begin
    cachereq_rdy      = 1'b0;
    cacheresp_val     = 1'b0;
    memreq_val        = 1'b0;
    memresp_rdy       = 1'b0;
    memreq_type       = req_read;
    req_reg_en        = 1'b0;
    tag_array_ren     = 1'b0;
    tag_array_wen     = 1'b0;
    data_array_ren    = 1'b0;
    data_array_wen    = 1'b0;
    data_array_wben   = wben_none;
    write_data_sel    = wdata_word;
    evict_addr_reg_en = 1'b0;
    memreq_addr_sel   = maddr_refill;
    refill_reg_en     = 1'b0;
    read_data_reg_en  = 1'b0;
    case (state)
      st_idle: begin
        cachereq_rdy  = 1'b1;
        req_reg_en    = cachereq_val;
        tag_array_ren = 1'b1;
      end
      // Line read starts here so a hit needs no extra cycle
      st_tag_check:     data_array_ren = 1'b1;
      st_read_access:   read_data_reg_en = 1'b1;
      st_write_access: begin
        tag_array_wen   = (req_type == req_init);
        data_array_wen  = 1'b1;
        data_array_wben = wben_word;
      end
      st_resp:          cacheresp_val = 1'b1;
      st_evict_prepare: evict_addr_reg_en = 1'b1;
      st_evict_request: begin
        memreq_val      = 1'b1;
        memreq_type     = req_write;
        memreq_addr_sel = maddr_evict;
      end
      st_evict_wait:    memresp_rdy = 1'b1;
      st_refill_request: memreq_val = 1'b1;
      st_refill_wait: begin
        memresp_rdy   = 1'b1;
        refill_reg_en = memresp_val;
      end
      st_refill_update: begin
        tag_array_wen   = 1'b1;
        data_array_wen  = 1'b1;
        data_array_ren  = 1'b1;
        data_array_wben = wben_line;
        write_data_sel  = wdata_refill;
      end
      default: begin
        cachereq_rdy = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/cache_dpath.sv
// Blocking cache datapath
// Request registers, tag and data arrays, eviction address and word muxing

`default_nettype none

module cache_dpath (
  input  wire logic                                 clk,
  input  wire logic                                 reset,
  input  wire cache_pkg::req_type_t                 cachereq_type,
  input  wire logic [cache_pkg::addr_bits-1:0]      cachereq_addr,
  input  wire logic [cache_pkg::word_bits-1:0]      cachereq_data,
  input  wire logic [cache_pkg::line_bits-1:0]      memresp_data,
  input  wire logic                                 req_reg_en,
  input  wire logic                                 tag_array_ren,
  input  wire logic                                 tag_array_wen,
  input  wire logic                                 data_array_ren,
  input  wire logic                                 data_array_wen,
  input  wire logic [cache_pkg::line_bytes-1:0]     data_array_wben,
  input  wire logic                                 write_data_sel,
  input  wire logic                                 evict_addr_reg_en,
  input  wire logic                                 memreq_addr_sel,
  input  wire logic                                 refill_reg_en,
  input  wire logic                                 read_data_reg_en,
  output logic                                      tag_match,
  output cache_pkg::req_type_t                      req_type,
  output logic [cache_pkg::index_bits-1:0]          req_index,
  output logic [cache_pkg::word_bits-1:0]           cacheresp_data,
  output logic [cache_pkg::addr_bits-1:0]           memreq_addr,
  output logic [cache_pkg::line_bits-1:0]           memreq_data
);

  import cache_pkg::*;

  cache_addr_u           in_addr;
  cache_addr_u           req_addr;
  logic [addr_bits-1:0]  evict_addr;
  logic [addr_bits-1:0]  refill_addr;
  logic [word_bits-1:0]  req_data;
  logic [line_bits-1:0]  refill_line;

  logic [tag_bits-1:0]   tag_array [num_lines];
  logic [tag_bits-1:0]   tag_rdata;
  logic [line_bits-1:0]  data_array [num_lines];
  logic [line_bits-1:0]  data_rdata;

  logic [line_bits-1:0]  write_line;
  logic [line_bits-1:0]  merged_line;
  logic [line_bytes-1:0] wben_eff;
  logic [word_bits-1:0]  read_word;
  logic [word_bits-1:0]  resp_word;

  assign in_addr.word = cachereq_addr;

  // --------------------------------------------------
  // Registered request
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      req_type <= req_read;
    end else if (req_reg_en) begin
      req_type <= cachereq_type;
    end
  end

  always_ff @(posedge clk) begin
    if (req_reg_en) begin
      req_addr <= in_addr;
      req_data <= cachereq_data;
    end
  end

  assign req_index = req_addr.fields.index;

  // --------------------------------------------------
  // Tag array
  // --------------------------------------------------
  // Read with the incoming index while the request is taken
  always_ff @(posedge clk) begin
    if (tag_array_ren) begin
      tag_rdata <= tag_array[in_addr.fields.index];
    end
    if (tag_array_wen) begin
      tag_array[req_index] <= req_addr.fields.tag;
    end
  end

  assign tag_match = (tag_rdata == req_addr.fields.tag);

  // Victim line address
  always_ff @(posedge clk) begin
    if (evict_addr_reg_en) begin
      evict_addr <= {tag_rdata, req_index, {offset_bits{1'b0}}};
    end
  end

  assign refill_addr = {req_addr.word[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
  assign memreq_addr = (memreq_addr_sel == maddr_refill) ? refill_addr : evict_addr;

  always_ff @(posedge clk) begin
    if (refill_reg_en) begin
      refill_line <= memresp_data;
    end
  end

  // --------------------------------------------------
  // Data array
  // --------------------------------------------------
  assign write_line = (write_data_sel == wdata_refill) ? refill_line : {4{req_data}};

  // Word writes move the lane 0 group to the addressed word
  assign wben_eff = (write_data_sel == wdata_refill)
                  ? data_array_wben
                  : data_array_wben << {req_addr.fields.word_sel, 2'b00};

  always_comb begin
    for (int b = 0; b < line_bytes; b++) begin
      merged_line[b*8 +: 8] = wben_eff[b] ? write_line[b*8 +: 8]
                                          : data_array[req_index][b*8 +: 8];
    end
  end

  // Write first, so a read during refill sees the new line
  always_ff @(posedge clk) begin
    if (data_array_wen) begin
      data_array[req_index] <= merged_line;
    end
    if (data_array_ren) begin
      data_rdata <= data_array_wen ? merged_line : data_array[req_index];
    end
  end

  assign memreq_data = data_rdata;

  // --------------------------------------------------
  // Response word
  // --------------------------------------------------
  always_comb begin
    case (req_addr.fields.word_sel)
      2'd0:    read_word = data_rdata[0*word_bits +: word_bits];
      2'd1:    read_word = data_rdata[1*word_bits +: word_bits];
      2'd2:    read_word = data_rdata[2*word_bits +: word_bits];
      default: read_word = data_rdata[3*word_bits +: word_bits];
    endcase
  end

  always_ff @(posedge clk) begin
    if (read_data_reg_en) begin
      resp_word <= read_word;
    end
  end

  assign cacheresp_data = resp_word;

endmodule

`default_nettype wire

//--- verilog/blocking_cache.sv
// Blocking direct-mapped write-back data cache
// Joins the controller and the datapath to the processor and memory ports

`default_nettype none

module blocking_cache (
  input  wire logic                                 clk,
  input  wire logic                                 reset,

  // Processor request and response
  input  wire logic                                 cachereq_val,
  output logic                                      cachereq_rdy,
  input  wire cache_pkg::req_type_t                 cachereq_type,
  input  wire logic [cache_pkg::addr_bits-1:0]      cachereq_addr,
  input  wire logic [cache_pkg::word_bits-1:0]      cachereq_data,
  output logic                                      cacheresp_val,
  input  wire logic                                 cacheresp_rdy,
  output cache_pkg::req_type_t                      cacheresp_type,
  output logic [cache_pkg::word_bits-1:0]           cacheresp_data,

  // Line-wide memory port
  output logic                                      memreq_val,
  input  wire logic                                 memreq_rdy,
  output cache_pkg::req_type_t                      memreq_type,
  output logic [cache_pkg::addr_bits-1:0]           memreq_addr,
  output logic [cache_pkg::line_bits-1:0]           memreq_data,
  input  wire logic                                 memresp_val,
  output logic                                      memresp_rdy,
  input  wire logic [cache_pkg::line_bits-1:0]      memresp_data
);

  import cache_pkg::*;

  // Controller enables
  logic                  req_reg_en;
  logic                  tag_array_ren;
  logic                  tag_array_wen;
  logic                  data_array_ren;
  logic                  data_array_wen;
  logic [line_bytes-1:0] data_array_wben;
  logic                  write_data_sel;
  logic                  evict_addr_reg_en;
  logic                  memreq_addr_sel;
  logic                  refill_reg_en;
  logic                  read_data_reg_en;

  // Datapath status
  logic                  tag_match;
  req_type_t             req_type;
  logic [index_bits-1:0] req_index;

  cache_ctrl ctrl (
    .clk               (clk),
    .reset             (reset),
    .cachereq_val      (cachereq_val),
    .cacheresp_rdy     (cacheresp_rdy),
    .memreq_rdy        (memreq_rdy),
    .memresp_val       (memresp_val),
    .tag_match         (tag_match),
    .req_type          (req_type),
    .req_index         (req_index),
    .cachereq_rdy      (cachereq_rdy),
    .cacheresp_val     (cacheresp_val),
    .memreq_val        (memreq_val),
    .memresp_rdy       (memresp_rdy),
    .memreq_type       (memreq_type),
    .cacheresp_type    (cacheresp_type),
    .req_reg_en        (req_reg_en),
    .tag_array_ren     (tag_array_ren),
    .tag_array_wen     (tag_array_wen),
    .data_array_ren    (data_array_ren),
    .data_array_wen    (data_array_wen),
    .data_array_wben   (data_array_wben),
    .write_data_sel    (write_data_sel),
    .evict_addr_reg_en (evict_addr_reg_en),
    .memreq_addr_sel   (memreq_addr_sel),
    .refill_reg_en     (refill_reg_en),
    .read_data_reg_en  (read_data_reg_en)
  );

  cache_dpath dpath (
    .clk               (clk),
    .reset             (reset),
    .cachereq_type     (cachereq_type),
    .cachereq_addr     (cachereq_addr),
    .cachereq_data     (cachereq_data),
    .memresp_data      (memresp_data),
    .req_reg_en        (req_reg_en),
    .tag_array_ren     (tag_array_ren),
    .tag_array_wen     (tag_array_wen),
    .data_array_ren    (data_array_ren),
    .data_array_wen    (data_array_wen),
    .data_array_wben   (data_array_wben),
    .write_data_sel    (write_data_sel),
    .evict_addr_reg_en (evict_addr_reg_en),
    .memreq_addr_sel   (memreq_addr_sel),
    .refill_reg_en     (refill_reg_en),
    .read_data_reg_en  (read_data_reg_en),
    .tag_match         (tag_match),
    .req_type          (req_type),
    .req_index         (req_index),
    .cacheresp_data    (cacheresp_data),
    .memreq_addr       (memreq_addr),
    .memreq_data       (memreq_data)
  );

endmodule

`default_nettype wire

//--- verification/cache_mem_model.sv
// Behavioral main memory for the cache testbench
// Line-wide reads and writes with random handshake delays

`default_nettype none

module cache_mem_model (
  input  wire logic                            clk,
  input  wire logic                            reset,
  input  wire logic                            memreq_val,
  output logic                                 memreq_rdy,
  input  wire cache_pkg::req_type_t            memreq_type,
  input  wire logic [cache_pkg::addr_bits-1:0] memreq_addr,
  input  wire logic [cache_pkg::line_bits-1:0] memreq_data,
  output logic                                 memresp_val,
  input  wire logic                            memresp_rdy,
  output logic [cache_pkg::line_bits-1:0]      memresp_data
);

  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  localparam int num_mem_lines = 256;
  // Each word holds its own byte address XOR this key
  localparam logic [31:0] fill_key = 32'h3c5a_0000;

  logic [line_bits-1:0] lines [num_mem_lines];
  integer               seed;
  logic [7:0]           line_idx;
  req_type_t            req_kind;
  logic [line_bits-1:0] wr_line;

  // Zero to three idle cycles
  task automatic wait_random();
    int n;
    n = $random(seed) & 3;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    seed         = 32'he9524d32;
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp_data = '0;
    for (int l = 0; l < num_mem_lines; l++) begin
      for (int w = 0; w < 4; w++) begin
        lines[l][w*32 +: 32] = (l * 16 + w * 4) ^ fill_key;
      end
    end
    forever begin
      @(posedge clk);
      #1;
      if (!reset && memreq_val) begin
        wait_random();
        memreq_rdy = 1'b1;
        line_idx   = memreq_addr[11:4];
        req_kind   = memreq_type;
        wr_line    = memreq_data;
        @(posedge clk);
        #1;
        memreq_rdy = 1'b0;
        if (req_kind == req_write) begin
          lines[line_idx] = wr_line;
          memresp_data    = '0;
        end else begin
          memresp_data = lines[line_idx];
        end
        wait_random();
        memresp_val = 1'b1;
        while (!memresp_rdy) begin
          @(posedge clk);
          #1;
        end
        @(posedge clk);
        #1;
        memresp_val = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/cache_tb.sv
// Testbench for the blocking data cache
// Directed tests and a random mix checked against a word-level reference

`default_nettype none

module cache_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  localparam int reset_cycles      = 16;
  localparam int miss_bound        = 60;
  localparam int directed_requests = 14;
  localparam int random_requests   = 200;
  localparam int watchdog_cycles   =
    reset_cycles + (directed_requests + random_requests) * miss_bound;
  // Same fill rule as the memory model
  localparam logic [31:0] fill_key = 32'h3c5a_0000;

  logic                 clk;
  logic                 reset;
  logic                 cachereq_val;
  logic                 cachereq_rdy;
  req_type_t            cachereq_type;
  logic [addr_bits-1:0] cachereq_addr;
  logic [word_bits-1:0] cachereq_data;
  logic                 cacheresp_val;
  logic                 cacheresp_rdy;
  req_type_t            cacheresp_type;
  logic [word_bits-1:0] cacheresp_data;
  logic                 memreq_val;
  logic                 memreq_rdy;
  req_type_t            memreq_type;
  logic [addr_bits-1:0] memreq_addr;
  logic [line_bits-1:0] memreq_data;
  logic                 memresp_val;
  logic                 memresp_rdy;
  logic [line_bits-1:0] memresp_data;

  // Reference copy of the first 4 KB, one entry per word
  logic [31:0] ref_words [1024];
  integer      seed;
  int          errors;
  int          checks;

  blocking_cache dut (
    .clk            (clk),
    .reset          (reset),
    .cachereq_val   (cachereq_val),
    .cachereq_rdy   (cachereq_rdy),
    .cachereq_type  (cachereq_type),
    .cachereq_addr  (cachereq_addr),
    .cachereq_data  (cachereq_data),
    .cacheresp_val  (cacheresp_val),
    .cacheresp_rdy  (cacheresp_rdy),
    .cacheresp_type (cacheresp_type),
    .cacheresp_data (cacheresp_data),
    .memreq_val     (memreq_val),
    .memreq_rdy     (memreq_rdy),
    .memreq_type    (memreq_type),
    .memreq_addr    (memreq_addr),
    .memreq_data    (memreq_data),
    .memresp_val    (memresp_val),
    .memresp_rdy    (memresp_rdy),
    .memresp_data   (memresp_data)
  );

  cache_mem_model mem (
    .clk          (clk),
    .reset        (reset),
    .memreq_val   (memreq_val),
    .memreq_rdy   (memreq_rdy),
    .memreq_type  (memreq_type),
    .memreq_addr  (memreq_addr),
    .memreq_data  (memreq_data),
    .memresp_val  (memresp_val),
    .memresp_rdy  (memresp_rdy),
    .memresp_data (memresp_data)
  );

  always #2 clk = ~clk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [31:0] make_addr(input int tag, input int index, input int word);
    cache_addr_u a;
    a.fields.tag      = tag[23:0];
    a.fields.index    = index[3:0];
    a.fields.word_sel = word[1:0];
    a.fields.byte_sel = 2'b00;
    return a.word;
  endfunction

  // Holds the request until the cache takes it
  task automatic issue_request(input req_type_t rtype, input logic [31:0] addr,
                               input logic [31:0] wdata);
    cachereq_val  = 1'b1;
    cachereq_type = rtype;
    cachereq_addr = addr;
    cachereq_data = wdata;
    while (!cachereq_rdy) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    cachereq_val = 1'b0;
  endtask

  // Latency counts cycles from acceptance to the first cacheresp_val
  task automatic await_response(input int stall_pct, output logic [31:0] rdata,
                                output req_type_t rtype, output int latency);
    int cycles;
    int roll;
    cycles  = 1;
    latency = 0;
    while (1) begin
      if (cacheresp_val) begin
        if (latency == 0) begin
          latency = cycles;
        end
        roll          = $random(seed) & 32'h7fff_ffff;
        cacheresp_rdy = (roll % 100) >= stall_pct;
        if (cacheresp_rdy) begin
          break;
        end
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    rdata = cacheresp_data;
    rtype = cacheresp_type;
    @(posedge clk);
    #1;
  endtask

  task automatic send_request(input req_type_t rtype, input logic [31:0] addr,
                              input logic [31:0] wdata, input int stall_pct,
                              output logic [31:0] rdata, output req_type_t resp_type,
                              output int latency);
    issue_request(rtype, addr, wdata);
    await_response(stall_pct, rdata, resp_type, latency);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic check_reset_state();
    check_value("reset cachereq_rdy", 32'd1, 32'(cachereq_rdy));
    check_value("reset cacheresp_val", 32'd0, 32'(cacheresp_val));
    check_value("reset memreq_val", 32'd0, 32'(memreq_val));
    check_value("reset memresp_rdy", 32'd0, 32'(memresp_rdy));
  endtask

  // Init data lives only in the cache, so the reference is left alone
  task automatic init_then_read();
    logic [31:0] addr;
    logic [31:0] rdata;
    req_type_t   rtype;
    int          lat;
    addr = make_addr(8, 5, 2);
    send_request(req_init, addr, 32'hc0ff_ee01, 0, rdata, rtype, lat);
    check_value("init resp type", 32'(req_init), 32'(rtype));
    send_request(req_read, addr, 32'h0, 0, rdata, rtype, lat);
    check_value("init read data", 32'hc0ff_ee01, rdata);
    check_value("init read type", 32'(req_read), 32'(rtype));
    check_value("init read latency", 32'd3, 32'(lat));
  endtask

  task automatic write_hit_lanes();
    logic [31:0] addr;
    logic [31:0] rdata;
    req_type_t   rtype;
    int          lat;
    addr = make_addr(9, 6, 0);
    send_request(req_read, addr, 32'h0, 0, rdata, rtype, lat);
    check_value("write hit fill", ref_words[addr[11:2]], rdata);
    addr = make_addr(9, 6, 2);
    send_request(req_write, addr, 32'h1234_abcd, 0, rdata, rtype, lat);
    ref_words[addr[11:2]] = 32'h1234_abcd;
    check_value("write hit type", 32'(req_write), 32'(rtype));
    check_value("write hit latency", 32'd3, 32'(lat));
    for (int w = 0; w < 4; w++) begin
      addr = make_addr(9, 6, w);
      send_request(req_read, addr, 32'h0, 0, rdata, rtype, lat);
      check_value($sformatf("write hit lane %0d", w), ref_words[addr[11:2]], rdata);
    end
  endtask

  task automatic read_miss_fill();
    logic [31:0] addr;
    logic [31:0] rdata;
    req_type_t   rtype;
    int          lat;
    addr = make_addr(10, 7, 1);
    send_request(req_read, addr, 32'h0, 0, rdata, rtype, lat);
    check_value("read miss data", addr ^ fill_key, rdata);
    addr = make_addr(10, 7, 3);
    send_request(req_read, addr, 32'h0, 0, rdata, rtype, lat);
    check_value("read after fill data", addr ^ fill_key, rdata);
    check_value("read after fill latency", 32'd3, 32'(lat));
  endtask

  // Same index, different tag forces the dirty line out
  task automatic dirty_eviction();
    logic [31:0] first;
    logic [31:0] other;
    logic [31:0] rdata;
    req_type_t   rtype;
    int          lat;
    first = make_addr(11, 8, 0);
    other = make_addr(12, 8, 0);
    send_request(req_write, first, 32'hdead_0042, 0, rdata, rtype, lat);
    ref_words[first[11:2]] = 32'hdead_0042;
    send_request(req_read, other, 32'h0, 0, rdata, rtype, lat);
    check_value("evict conflict read", ref_words[other[11:2]], rdata);
    check_value("evict memory copy", 32'hdead_0042, mem.lines[first[11:4]][31:0]);
    send_request(req_read, first, 32'h0, 0, rdata, rtype, lat);
    check_value("evict reread", 32'hdead_0042, rdata);
  endtask

  task automatic response_backpressure();
    logic [31:0] addr;
    logic [31:0] held;
    addr          = make_addr(10, 7, 0);
    cacheresp_rdy = 1'b0;
    issue_request(req_read, addr, 32'h0);
    while (!cacheresp_val) begin
      @(posedge clk);
      #1;
    end
    held = cacheresp_data;
    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      #1;
      check_value("stall resp val", 32'd1, 32'(cacheresp_val));
      check_value("stall resp data", held, cacheresp_data);
      check_value("stall req rdy", 32'd0, 32'(cachereq_rdy));
    end
    check_value("stall data", ref_words[addr[11:2]], cacheresp_data);
    cacheresp_rdy = 1'b1;
    @(posedge clk);
    #1;
    check_value("stall released val", 32'd0, 32'(cacheresp_val));
    check_value("stall released rdy", 32'd1, 32'(cachereq_rdy));
  endtask

  // Four tags on four indices, random response stalls
  task automatic random_mix();
    int          tag;
    int          index;
    int          word;
    logic        is_write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    req_type_t   rtype;
    int          lat;
    for (int n = 0; n < random_requests; n++) begin
      tag      = 1 + ($random(seed) & 3);
      index    = $random(seed) & 3;
      word     = $random(seed) & 3;
      is_write = ($random(seed) & 1) != 0;
      addr     = make_addr(tag, index, word);
      if (is_write) begin
        wdata = $random(seed);
        send_request(req_write, addr, wdata, 25, rdata, rtype, lat);
        ref_words[addr[11:2]] = wdata;
        check_value("random write type", 32'(req_write), 32'(rtype));
      end else begin
        send_request(req_read, addr, 32'h0, 25, rdata, rtype, lat);
        check_value($sformatf("random read %h", addr), ref_words[addr[11:2]], rdata);
      end
    end
  endtask

  // --------------------------------------------------
  // Run control
  // --------------------------------------------------
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the cache stopped responding",
             watchdog_cycles);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_type = req_read;
    cachereq_addr = '0;
    cachereq_data = '0;
    cacheresp_rdy = 1'b1;
    seed          = 32'he9524d32;
    errors        = 0;
    checks        = 0;
    for (int i = 0; i < 1024; i++) begin
      ref_words[i] = (i * 4) ^ fill_key;
    end
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
    check_reset_state();
    init_then_read();
    write_hit_lanes();
    read_miss_fill();
    dirty_eviction();
    response_backpressure();
    random_mix();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
verilog/cache_pkg.sv
verilog/cache_ctrl.sv
verilog/cache_dpath.sv
verilog/blocking_cache.sv
verification/cache_mem_model.sv
verification/cache_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
  --top-module cache_tb --Mdir obj_dir -o cache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
  exit 0
fi
exit 1
